// File: design/dispatchPkg.sv
// dispatch widths and packet layouts; fixed four-lane group, counts are raw occupancy values
`default_nettype none

package dispatchPkg;

  localparam int dispatchWidth  = 4;   // lanes per group
  localparam int checkpoints    = 8;
  localparam int checkpointsLog = 3;
  localparam int sizeLsq        = 16;  // load queue and store queue each
  localparam int sizeIssueQ     = 32;
  localparam int sizeActiveList = 64;
  localparam int physRegLog     = 7;
  localparam int archRegLog     = 5;
  localparam int pcWidth        = 32;

  typedef logic [checkpoints-1:0]    branchMaskT;
  typedef logic [checkpointsLog-1:0] checkpointIdT;
  typedef logic [physRegLog-1:0]     physRegT;
  typedef logic [archRegLog-1:0]     archRegT;
  typedef logic [pcWidth-1:0]        pcT;

  // renamed instruction, only the fields dispatch reads or routes
  typedef struct packed {
    archRegT      archDest;
    logic         isStore;
    logic         isLoad;
    branchMaskT   branchMask;
    checkpointIdT checkpointId;
    physRegT      physSrc1;
    physRegT      physSrc2;
    physRegT      physDest;
    pcT           pc;
  } renamedPktT;

  // issue queue entry, mask already updated for verified branches
  typedef struct packed {
    archRegT      archDest;
    logic         isStore;
    logic         isLoad;
    branchMaskT   branchMask;
    checkpointIdT checkpointId;
    physRegT      physSrc1;
    physRegT      physSrc2;
    physRegT      physDest;
  } issueqPktT;

  typedef struct packed {
    logic    isLoad;
    logic    isStore;
    pcT      pc;
    archRegT archDest;
    physRegT physDest;   // freed at retire via the arch mapping
  } alPktT;

  typedef struct packed {
    branchMaskT branchMask;
    logic       isStore;
    logic       isLoad;
  } lsqPktT;

  // occupancy reported by the back-end structures
  typedef struct packed {
    logic [3:0] spare;          // reserved
    logic [4:0] loadQueueCnt;
    logic [4:0] storeQueueCnt;
    logic [5:0] issueQueueCnt;
    logic [6:0] activeListCnt;
  } occupancyT;

  typedef struct packed {
    logic         valid;
    checkpointIdT checkpointId;
  } ctrlVerifyT;

endpackage

`default_nettype wire

// File: design/capacityCheck.sv
// group always takes a full four entries in issue queue and active list, counts assumed <= capacity
`timescale 1ns/1ns
`default_nettype none

module capacityCheck
  import dispatchPkg::*;
(
  input  renamedPktT renamedGroup_i [dispatchWidth],
  input  occupancyT  occupancy_i,
  output logic       stall_o
);

  logic [2:0] loadCnt;     // up to four per group
  logic [2:0] storeCnt;
  logic [5:0] loadSum;
  logic [5:0] storeSum;
  logic [6:0] issueSum;
  logic [7:0] activeSum;

  always_comb
  begin
    loadCnt  = '0;
    storeCnt = '0;
    for (int i = 0; i < dispatchWidth; i++)
    begin
      loadCnt  = loadCnt + {2'b00, renamedGroup_i[i].isLoad};
      storeCnt = storeCnt + {2'b00, renamedGroup_i[i].isStore};
    end
  end

  // sums are one bit wider than the counts so nothing wraps
  assign loadSum   = {1'b0, occupancy_i.loadQueueCnt} + {3'b000, loadCnt};
  assign storeSum  = {1'b0, occupancy_i.storeQueueCnt} + {3'b000, storeCnt};
  assign issueSum  = {1'b0, occupancy_i.issueQueueCnt} + 7'(dispatchWidth);
  assign activeSum = {1'b0, occupancy_i.activeListCnt} + 8'(dispatchWidth);

  assign stall_o = (loadSum > 6'(sizeLsq))
                 | (storeSum > 6'(sizeLsq))
                 | (issueSum > 7'(sizeIssueQ))
                 | (activeSum > 8'(sizeActiveList));

endmodule

`default_nettype wire

// File: design/branchMaskClear.sv
// one verify report per cycle, clears a single checkpoint bit in every lane
`timescale 1ns/1ns
`default_nettype none

module branchMaskClear
  import dispatchPkg::*;
(
  input  renamedPktT renamedGroup_i [dispatchWidth],
  input  ctrlVerifyT ctrlVerify_i,
  output branchMaskT clearedMask_o [dispatchWidth]
);

  branchMaskT keepMask;   // zero only at the verified checkpoint

  always_comb
  begin
    keepMask = '1;
    if (ctrlVerify_i.valid)
      keepMask[ctrlVerify_i.checkpointId] = 1'b0;
  end

  always_comb
  begin
    for (int i = 0; i < dispatchWidth; i++)
      clearedMask_o[i] = renamedGroup_i[i].branchMask & keepMask;
  end

endmodule

`default_nettype wire

// File: design/packetFormer.sv
// pure field routing; the lane mask comes from the clear logic, never from the raw packet
`timescale 1ns/1ns
`default_nettype none

module packetFormer
  import dispatchPkg::*;
(
  input  renamedPktT renamedGroup_i [dispatchWidth],
  input  branchMaskT clearedMask_i  [dispatchWidth],
  output issueqPktT  issueqPkt_o    [dispatchWidth],
  output alPktT      alPkt_o        [dispatchWidth],
  output lsqPktT     lsqPkt_o       [dispatchWidth]
);

  always_comb
  begin
    for (int i = 0; i < dispatchWidth; i++)
    begin
      // issue queue gets everything but the pc
      issueqPkt_o[i].archDest     = renamedGroup_i[i].archDest;
      issueqPkt_o[i].isStore      = renamedGroup_i[i].isStore;
      issueqPkt_o[i].isLoad       = renamedGroup_i[i].isLoad;
      issueqPkt_o[i].branchMask   = clearedMask_i[i];
      issueqPkt_o[i].checkpointId = renamedGroup_i[i].checkpointId;
      issueqPkt_o[i].physSrc1     = renamedGroup_i[i].physSrc1;
      issueqPkt_o[i].physSrc2     = renamedGroup_i[i].physSrc2;
      issueqPkt_o[i].physDest     = renamedGroup_i[i].physDest;

      alPkt_o[i].isLoad   = renamedGroup_i[i].isLoad;
      alPkt_o[i].isStore  = renamedGroup_i[i].isStore;
      alPkt_o[i].pc       = renamedGroup_i[i].pc;        // for precise exceptions
      alPkt_o[i].archDest = renamedGroup_i[i].archDest;
      alPkt_o[i].physDest = renamedGroup_i[i].physDest;

      // lsq only needs the mask for squash and the access kind
      lsqPkt_o[i].branchMask = clearedMask_i[i];
      lsqPkt_o[i].isStore    = renamedGroup_i[i].isStore;
      lsqPkt_o[i].isLoad     = renamedGroup_i[i].isLoad;
    end
  end

endmodule

`default_nettype wire

// File: design/dispatchLatch.sv
// holds one group per cycle; valid drops after any cycle without a load, payload then holds
`timescale 1ns/1ns
`default_nettype none

module dispatchLatch
  import dispatchPkg::*;
#(
  parameter type payloadT = logic
)
(
  input  logic    clk,
  input  logic    rstN_i,
  input  logic    load_i,
  input  payloadT payload_i [dispatchWidth],
  output payloadT payload_o [dispatchWidth],
  output logic    valid_o
);

  payloadT payloadQ [dispatchWidth];
  logic    validQ;

  always_ff @(posedge clk)
  begin
    if (!rstN_i)
    begin
      validQ <= 1'b0;
      for (int i = 0; i < dispatchWidth; i++)
        payloadQ[i] <= '0;
    end
    else
    begin
      validQ <= load_i;          // one cycle behind accept
      if (load_i)
        payloadQ <= payload_i;
    end
  end

  assign payload_o = payloadQ;
  assign valid_o   = validQ;

endmodule

`default_nettype wire

// File: design/dispatch.sv
// four-wide dispatch; rename must hold its group while backEndReady_o is low
`timescale 1ns/1ns
`default_nettype none

module dispatch
  import dispatchPkg::*;
(
  input  logic       clk,
  input  logic       rstN_i,
  input  logic       renameReady_i,      // rename holds a full group
  input  logic       flagRecoverEx_i,    // mispredict recovery in progress
  input  ctrlVerifyT ctrlVerify_i,
  input  renamedPktT renamedGroup_i [dispatchWidth],
  input  occupancyT  occupancy_i,

  // masks fed back so a stalled group in the rename register stays current
  output branchMaskT updatedMask_o  [dispatchWidth],
  output logic       backEndReady_o,
  output logic       stallFrontEnd_o,

  output issueqPktT  issueqPkt_o    [dispatchWidth],
  output alPktT      alPkt_o        [dispatchWidth],
  output lsqPktT     lsqPkt_o       [dispatchWidth],
  output logic       dispatchValid_o
);

  logic      capStall;
  logic      accept;
  issueqPktT issueqNext [dispatchWidth];
  alPktT     alNext     [dispatchWidth];
  lsqPktT    lsqNext    [dispatchWidth];

  capacityCheck u_capacityCheck (
    .renamedGroup_i (renamedGroup_i),
    .occupancy_i    (occupancy_i),
    .stall_o        (capStall)
  );

  branchMaskClear u_branchMaskClear (
    .renamedGroup_i (renamedGroup_i),
    .ctrlVerify_i   (ctrlVerify_i),
    .clearedMask_o  (updatedMask_o)
  );

  packetFormer u_packetFormer (
    .renamedGroup_i (renamedGroup_i),
    .clearedMask_i  (updatedMask_o),
    .issueqPkt_o    (issueqNext),
    .alPkt_o        (alNext),
    .lsqPkt_o       (lsqNext)
  );

  // stall reports capacity only; ready also folds in rename and recovery
  assign accept          = renameReady_i & ~flagRecoverEx_i & ~capStall;
  assign backEndReady_o  = accept;
  assign stallFrontEnd_o = capStall;

  dispatchLatch #(.payloadT(issueqPktT)) u_issueqLatch (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .load_i    (accept),
    .payload_i (issueqNext),
    .payload_o (issueqPkt_o),
    .valid_o   (dispatchValid_o)   // all three latches load together
  );

  dispatchLatch #(.payloadT(alPktT)) u_alLatch (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .load_i    (accept),
    .payload_i (alNext),
    .payload_o (alPkt_o),
    .valid_o   ()
  );

  dispatchLatch #(.payloadT(lsqPktT)) u_lsqLatch (
    .clk       (clk),
    .rstN_i    (rstN_i),
    .load_i    (accept),
    .payload_i (lsqNext),
    .payload_o (lsqPkt_o),
    .valid_o   ()
  );

endmodule

`default_nettype wire

// File: bench/tbDispatch.sv
// directed tests with a single group checked per step; expects exactly one cycle of latch latency
`timescale 1ns/1ns
`default_nettype none

module tbDispatch
  import dispatchPkg::*;
();

  localparam int simLimitNs = 100000;

  logic       clk;
  logic       rstN;
  logic       renameReady;
  logic       flagRecoverEx;
  ctrlVerifyT ctrlVerify;
  renamedPktT group       [dispatchWidth];
  occupancyT  occupancy;
  branchMaskT updatedMask [dispatchWidth];
  logic       backEndReady;
  logic       stallFrontEnd;
  issueqPktT  issueqPkt   [dispatchWidth];
  alPktT      alPkt       [dispatchWidth];
  lsqPktT     lsqPkt      [dispatchWidth];
  logic       dispatchValid;

  renamedPktT  sentGroup [dispatchWidth];   // group offered at the last check
  ctrlVerifyT  sentVerify;
  logic [31:0] rngState;
  int          errorCount;

  dispatch u_dispatch (
    .clk             (clk),
    .rstN_i          (rstN),
    .renameReady_i   (renameReady),
    .flagRecoverEx_i (flagRecoverEx),
    .ctrlVerify_i    (ctrlVerify),
    .renamedGroup_i  (group),
    .occupancy_i     (occupancy),
    .updatedMask_o   (updatedMask),
    .backEndReady_o  (backEndReady),
    .stallFrontEnd_o (stallFrontEnd),
    .issueqPkt_o     (issueqPkt),
    .alPkt_o         (alPkt),
    .lsqPkt_o        (lsqPkt),
    .dispatchValid_o (dispatchValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial
  begin
    #simLimitNs;
    failNow("simulation ran past its time limit");
  end

  task automatic failNow(input string line);
    errorCount++;
    $display("%s", line);
    $display("Done: errors found");
    $fatal(1);
  endtask

  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  // expected mask: every bit kept except the one a valid report names
  function automatic branchMaskT clearedMask(input branchMaskT m, input ctrlVerifyT v);
    branchMaskT res;
    for (int b = 0; b < checkpoints; b++)
      res[b] = m[b] && !(v.valid && (int'(v.checkpointId) == b));
    return res;
  endfunction

  function automatic issueqPktT expIssueq(input renamedPktT p, input ctrlVerifyT v);
    issueqPktT e;
    e.archDest     = p.archDest;
    e.isStore      = p.isStore;
    e.isLoad       = p.isLoad;
    e.branchMask   = clearedMask(p.branchMask, v);
    e.checkpointId = p.checkpointId;
    e.physSrc1     = p.physSrc1;
    e.physSrc2     = p.physSrc2;
    e.physDest     = p.physDest;
    return e;
  endfunction

  function automatic alPktT expAl(input renamedPktT p);
    alPktT e;
    e.isLoad   = p.isLoad;
    e.isStore  = p.isStore;
    e.pc       = p.pc;
    e.archDest = p.archDest;
    e.physDest = p.physDest;
    return e;
  endfunction

  function automatic lsqPktT expLsq(input renamedPktT p, input ctrlVerifyT v);
    lsqPktT e;
    e.branchMask = clearedMask(p.branchMask, v);
    e.isStore    = p.isStore;
    e.isLoad     = p.isLoad;
    return e;
  endfunction

  task automatic checkIssueq(input string what, input issueqPktT got, input issueqPktT exp);
    if (got !== exp)
      failNow($sformatf("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic checkAl(input string what, input alPktT got, input alPktT exp);
    if (got !== exp)
      failNow($sformatf("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic checkLsq(input string what, input lsqPktT got, input lsqPktT exp);
    if (got !== exp)
      failNow($sformatf("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic checkMask(input string what, input branchMaskT got, input branchMaskT exp);
    if (got !== exp)
      failNow($sformatf("ERROR at %0t ns: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic checkBit(input string what, input logic got, input logic exp);
    if (got !== exp)
      failNow($sformatf("ERROR at %0t ns: %s got %b expected %b", $time, what, got, exp));
  endtask

  // polls on falling edges, so the first look is just after the next rising edge
  task automatic waitValid(input int maxCycles);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < maxCycles)
    begin
      @(negedge clk);
      waited++;
      seen = (dispatchValid === 1'b1);
    end
    if (!seen)
      failNow("timeout while waiting for dispatch valid to rise");
  endtask

  task automatic setOccupancy(input int lq, input int sq, input int iq, input int al);
    occupancy.spare         = '0;
    occupancy.loadQueueCnt  = 5'(lq);
    occupancy.storeQueueCnt = 5'(sq);
    occupancy.issueQueueCnt = 6'(iq);
    occupancy.activeListCnt = 7'(al);
  endtask

  // loads fill the low lanes, stores the lanes after them
  task automatic makeGroup(input int loads, input int stores);
    logic [31:0] r;
    for (int i = 0; i < dispatchWidth; i++)
    begin
      r = nextRandom();
      group[i].archDest     = r[4:0];
      group[i].physSrc1     = r[11:5];
      group[i].physSrc2     = r[18:12];
      group[i].physDest     = r[25:19];
      group[i].checkpointId = r[28:26];
      r = nextRandom();
      group[i].branchMask   = r[7:0];
      group[i].isLoad       = (i < loads);
      group[i].isStore      = (i >= loads) && (i < loads + stores);
      group[i].pc           = nextRandom();
    end
  endtask

  task automatic checkLatched(input string tag);
    for (int i = 0; i < dispatchWidth; i++)
    begin
      checkIssueq($sformatf("%s lane %0d issueq", tag, i), issueqPkt[i],
                  expIssueq(sentGroup[i], sentVerify));
      checkAl($sformatf("%s lane %0d al", tag, i), alPkt[i], expAl(sentGroup[i]));
      checkLsq($sformatf("%s lane %0d lsq", tag, i), lsqPkt[i],
               expLsq(sentGroup[i], sentVerify));
    end
  endtask

  // entered at a falling edge with the inputs already driven, leaves at a falling edge
  task automatic applyAndCheck(input string tag, input logic expStall);
    logic expReady;
    expReady = renameReady && !flagRecoverEx && !expStall;
    #2;
    checkBit({tag, " stall"}, stallFrontEnd, expStall);
    checkBit({tag, " ready"}, backEndReady, expReady);
    for (int i = 0; i < dispatchWidth; i++)
      checkMask({tag, " updated mask"}, updatedMask[i],
                clearedMask(group[i].branchMask, ctrlVerify));
    sentGroup  = group;
    sentVerify = ctrlVerify;
    if (expReady)
    begin
      waitValid(1);
      checkLatched(tag);
    end
    else
    begin
      @(negedge clk);
      checkBit({tag, " valid"}, dispatchValid, 1'b0);
    end
  endtask

  task automatic testReset();
    checkBit("valid after reset", dispatchValid, 1'b0);
    for (int i = 0; i < dispatchWidth; i++)
    begin
      checkIssueq("issueq after reset", issueqPkt[i], '0);
      checkAl("al after reset", alPkt[i], '0);
      checkLsq("lsq after reset", lsqPkt[i], '0);
    end
  endtask

  task automatic testRouting();
    setOccupancy(0, 0, 0, 0);
    renameReady = 1'b1;
    makeGroup(1, 2);
    applyAndCheck("routing", 1'b0);
  endtask

  task automatic testCapacity();
    setOccupancy(sizeLsq - 2, 0, 0, 0);
    makeGroup(3, 0);
    applyAndCheck("lq over", 1'b1);
    makeGroup(2, 0);
    applyAndCheck("lq at limit", 1'b0);
    setOccupancy(0, sizeLsq - 2, 0, 0);
    makeGroup(0, 3);
    applyAndCheck("sq over", 1'b1);
    makeGroup(0, 2);
    applyAndCheck("sq at limit", 1'b0);
    makeGroup(1, 1);
    setOccupancy(0, 0, 29, 0);
    applyAndCheck("iq over", 1'b1);
    setOccupancy(0, 0, 28, 0);
    applyAndCheck("iq at limit", 1'b0);
    setOccupancy(0, 0, 0, 61);
    applyAndCheck("al over", 1'b1);
    setOccupancy(0, 0, 0, 60);
    applyAndCheck("al at limit", 1'b0);
    setOccupancy(0, 0, 0, 0);
  endtask

  task automatic testNotReady();
    renameReady = 1'b0;
    makeGroup(1, 1);
    applyAndCheck("rename not ready", 1'b0);
    renameReady   = 1'b1;
    flagRecoverEx = 1'b1;
    applyAndCheck("recovery", 1'b0);
    setOccupancy(sizeLsq, 0, 0, 0);
    applyAndCheck("recovery with lq full", 1'b1);
    flagRecoverEx = 1'b0;
    renameReady   = 1'b0;
    applyAndCheck("rename not ready with lq full", 1'b1);
    renameReady   = 1'b1;
    setOccupancy(0, 0, 0, 0);
    applyAndCheck("after recovery", 1'b0);
  endtask

  task automatic testMaskClear();
    logic [31:0] r;
    for (int n = 0; n < 6; n++)
    begin
      r = nextRandom();
      makeGroup(1, 0);
      group[0].branchMask     = '1;   // verified bit is surely set in lane 0
      ctrlVerify.valid        = 1'b1;
      ctrlVerify.checkpointId = r[2:0];
      applyAndCheck("verify valid", 1'b0);
    end
    ctrlVerify.valid = 1'b0;
    makeGroup(0, 1);
    applyAndCheck("verify invalid", 1'b0);
  endtask

  task automatic testBackToBack();
    logic [31:0] r;
    for (int n = 0; n < 10; n++)
    begin
      r = nextRandom();
      makeGroup(int'(r[1:0]) % 3, int'(r[2]));
      ctrlVerify.valid        = r[3];
      ctrlVerify.checkpointId = r[6:4];
      applyAndCheck("back to back", 1'b0);
    end
    ctrlVerify = '0;
  endtask

  initial
  begin
    rngState      = 32'h69eb;
    errorCount    = 0;
    rstN          = 1'b0;
    renameReady   = 1'b0;
    flagRecoverEx = 1'b0;
    ctrlVerify    = '0;
    occupancy     = '0;
    for (int i = 0; i < dispatchWidth; i++)
      group[i] = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    testReset();
    testRouting();
    testCapacity();
    testNotReady();
    testMaskClear();
    testBackToBack();
    if (errorCount == 0)
    begin
      $display("Done: no errors");
      $finish;
    end
    else
    begin
      $display("Done: errors found");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: flist.f
design/dispatchPkg.sv
design/capacityCheck.sv
design/branchMaskClear.sv
design/packetFormer.sv
design/dispatchLatch.sv
design/dispatch.sv
bench/tbDispatch.sv

// File: Makefile
# Verilator build and run for the dispatch stage

VERILATOR ?= verilator
TOP       ?= tbDispatch
FLIST     ?= flist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --timescale 1ns/1ns
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJDIR) -o V$(TOP)

run: build
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)
